/* hw/core_pkg.sv */
/*
 * ibex_lite shared definitions
 * Widths, opcode and ALU operation codes used across the core
 */
package core_pkg;

  // Data and address width
  localparam int unsigned XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [3:0]      be_t;
  typedef logic [2:0]      alu_op_t;

  //////////////////////////////////////////////////////////////////////
  // ALU operations
  //////////////////////////////////////////////////////////////////////

  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR  = 3'd3;
  localparam alu_op_t ALU_XOR = 3'd4;
  // Operand b passes through unchanged
  localparam alu_op_t ALU_LUI = 3'd5;

  //////////////////////////////////////////////////////////////////////
  // RV32I major opcodes
  //////////////////////////////////////////////////////////////////////

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // PC step, no compressed instructions
  localparam word_t INSTR_BYTES = 32'd4;

endpackage

/* hw/alu.sv */
/*
 * ALU with a shared adder/subtractor, logic operations
 * and an equality compare for branches
 */
module alu (
  input  core_pkg::alu_op_t op_i,
  input  core_pkg::word_t   operand_a_i,
  input  core_pkg::word_t   operand_b_i,
  output core_pkg::word_t   result_o,
  output logic              equal_o
);
  import core_pkg::*;

  logic  sub;
  word_t adder_b;
  word_t adder_result;

  // Subtract as a plus inverted b plus one
  assign sub          = (op_i == ALU_SUB);
  assign adder_b      = sub ? ~operand_b_i : operand_b_i;
  assign adder_result = operand_a_i + adder_b + word_t'(sub);

  always_comb begin
    unique case (op_i)
      ALU_ADD, ALU_SUB: result_o = adder_result;
      ALU_AND:          result_o = operand_a_i & operand_b_i;
      ALU_OR:           result_o = operand_a_i | operand_b_i;
      ALU_XOR:          result_o = operand_a_i ^ operand_b_i;
      ALU_LUI:          result_o = operand_b_i;
      default:          result_o = '0;
    endcase
  end

  assign equal_o = (operand_a_i == operand_b_i);

endmodule

/* hw/regfile.sv */
/*
 * Integer register file, two read ports and one write port
 * x0 reads as zero
 */
module regfile (
  input  logic                clk,
  input  logic                rst_ni,
  input  core_pkg::reg_addr_t raddr_a_i,
  input  core_pkg::reg_addr_t raddr_b_i,
  output core_pkg::word_t     rdata_a_o,
  output core_pkg::word_t     rdata_b_o,
  input  logic                we_i,
  input  core_pkg::reg_addr_t waddr_i,
  input  core_pkg::word_t     wdata_i
);
  import core_pkg::*;

  // x1 to x31
  word_t regs_q [31:1];

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* hw/lsu.sv */
/*
 * Load/store unit
 * Data bus master for word loads, word stores and byte stores
 */
module lsu (
  input  logic            clk,
  input  logic            rst_ni,
  input  logic            lsu_req_i,
  input  logic            lsu_we_i,
  input  logic            lsu_byte_i,
  input  core_pkg::word_t lsu_addr_i,
  input  core_pkg::word_t lsu_wdata_i,
  output logic            lsu_done_o,
  output core_pkg::word_t lsu_rdata_o,
  output logic            data_req_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  output logic            data_we_o,
  output core_pkg::be_t   data_be_o,
  output core_pkg::word_t data_addr_o,
  output core_pkg::word_t data_wdata_o,
  input  core_pkg::word_t data_rdata_i
);
  import core_pkg::*;

  logic  req_q;
  logic  wait_q;
  logic  we_q;
  be_t   be_q;
  word_t addr_q;
  word_t wdata_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q  <= 1'b0;
      wait_q <= 1'b0;
    end else begin
      if (lsu_req_i) begin
        req_q <= 1'b1;
      end else if (req_q && data_gnt_i) begin
        req_q <= 1'b0;
      end
      if (req_q && data_gnt_i) begin
        wait_q <= 1'b1;
      end else if (data_rvalid_i) begin
        wait_q <= 1'b0;
      end
    end
  end

  // Bus fields are held from here until the grant
  always_ff @(posedge clk) begin
    if (lsu_req_i) begin
      addr_q  <= {lsu_addr_i[XLEN-1:2], 2'b00};
      we_q    <= lsu_we_i;
      be_q    <= lsu_byte_i ? (4'b0001 << lsu_addr_i[1:0]) : 4'b1111;
      wdata_q <= lsu_byte_i ? {4{lsu_wdata_i[7:0]}} : lsu_wdata_i;
    end
  end

  assign data_req_o   = req_q;
  assign data_we_o    = we_q;
  assign data_be_o    = be_q;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;

  assign lsu_done_o  = wait_q & data_rvalid_i;
  assign lsu_rdata_o = data_rdata_i;

endmodule

/* hw/if_stage.sv */
/*
 * Instruction fetch stage
 * Issues word fetches, buffers one instruction for decode and
 * drops stale responses after a redirect
 */
module if_stage (
  input  logic            clk,
  input  logic            rst_ni,
  input  logic            fetch_enable_i,
  input  core_pkg::word_t boot_addr_i,
  output logic            instr_req_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  output core_pkg::word_t instr_addr_o,
  input  core_pkg::word_t instr_rdata_i,
  output logic            instr_valid_o,
  output core_pkg::word_t instr_o,
  output core_pkg::word_t pc_o,
  input  logic            instr_ack_i,
  input  logic            pc_set_i,
  input  core_pkg::word_t pc_target_i
);
  import core_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID
  } fetch_state_e;

  fetch_state_e state_q;
  fetch_state_e state_d;
  word_t        fetch_addr_q;
  // Address of the fetch on the bus
  word_t        addr_q;
  logic         discard_q;
  logic         buf_valid_q;
  word_t        buf_instr_q;
  word_t        buf_pc_q;
  // Prefetch that came back while the buffer was still held
  logic         rsp_valid_q;
  word_t        rsp_instr_q;
  logic         issue;
  logic         granted;
  logic         rvalid_ok;
  logic         buf_free;

  // New fetch only with no fetch in flight and the parking slot empty
  assign issue        = (state_q == IDLE) & fetch_enable_i & ~pc_set_i & ~rsp_valid_q;
  assign instr_req_o  = issue | (state_q == WAIT_GNT);
  assign instr_addr_o = (state_q == IDLE) ? fetch_addr_q : addr_q;
  assign granted      = instr_req_o & instr_gnt_i;
  assign rvalid_ok    = instr_rvalid_i & ~discard_q & ~pc_set_i;
  assign buf_free     = ~buf_valid_q | instr_ack_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (issue) begin
          state_d = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end
      end
      WAIT_GNT: begin
        if (instr_gnt_i) begin
          state_d = WAIT_RVALID;
        end
      end
      WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      fetch_addr_q <= {boot_addr_i[XLEN-1:2], 2'b00};
      discard_q    <= 1'b0;
      buf_valid_q  <= 1'b0;
      rsp_valid_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (pc_set_i) begin
        fetch_addr_q <= {pc_target_i[XLEN-1:2], 2'b00};
      end else if (granted && !discard_q) begin
        fetch_addr_q <= instr_addr_o + INSTR_BYTES;
      end
      // Stale response when a redirect meets a fetch on the bus
      if (pc_set_i && (state_q == WAIT_GNT || (state_q == WAIT_RVALID && !instr_rvalid_i))) begin
        discard_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        discard_q <= 1'b0;
      end
      if (pc_set_i) begin
        buf_valid_q <= 1'b0;
        rsp_valid_q <= 1'b0;
      end else if (rsp_valid_q && instr_ack_i) begin
        rsp_valid_q <= 1'b0;
      end else if (rvalid_ok) begin
        buf_valid_q <= 1'b1;
        rsp_valid_q <= ~buf_free;
      end else if (instr_ack_i) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      addr_q <= fetch_addr_q;
    end
    if (rsp_valid_q && instr_ack_i) begin
      buf_instr_q <= rsp_instr_q;
      buf_pc_q    <= addr_q;
    end else if (rvalid_ok && buf_free) begin
      buf_instr_q <= instr_rdata_i;
      buf_pc_q    <= addr_q;
    end
    if (rvalid_ok && !buf_free) begin
      rsp_instr_q <= instr_rdata_i;
    end
  end

  assign instr_valid_o = buf_valid_q;
  assign instr_o       = buf_instr_q;
  assign pc_o          = buf_pc_q;

endmodule

/* hw/id_ex_stage.sv */
/*
 * Decode and execute stage
 * Decodes the buffered instruction, writes back results, resolves
 * branches and JAL and hands memory accesses to the LSU
 */
module id_ex_stage (
  input  logic            clk,
  input  logic            rst_ni,
  input  logic            instr_valid_i,
  input  core_pkg::word_t instr_i,
  input  core_pkg::word_t pc_i,
  output logic            instr_ack_o,
  output logic            pc_set_o,
  output core_pkg::word_t pc_target_o,
  output logic            lsu_req_o,
  output logic            lsu_we_o,
  output logic            lsu_byte_o,
  output core_pkg::word_t lsu_addr_o,
  output core_pkg::word_t lsu_wdata_o,
  input  logic            lsu_done_i,
  input  core_pkg::word_t lsu_rdata_i
);
  import core_pkg::*;

  typedef enum logic {
    EXEC,
    WAIT_LSU
  } ex_state_e;

  ex_state_e  state_q;
  ex_state_e  state_d;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  word_t      rf_rdata_a;
  word_t      rf_rdata_b;
  word_t      rf_wdata;
  logic       rf_we;
  alu_op_t    alu_op;
  word_t      alu_b;
  word_t      alu_result;
  logic       alu_equal;
  logic       writes_rd;
  logic       is_load;
  logic       is_store;
  logic       is_byte;
  logic       is_branch;
  logic       is_jal;
  logic       branch_taken;

  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign funct7 = instr_i[31:25];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  //////////////////////////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_op    = ALU_ADD;
    alu_b     = rf_rdata_b;
    writes_rd = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_byte   = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    case (opcode)
      OPC_LUI: begin
        alu_op    = ALU_LUI;
        alu_b     = imm_u;
        writes_rd = 1'b1;
      end
      OPC_OPIMM: begin
        alu_b     = imm_i;
        writes_rd = (funct3 == 3'b000);
      end
      OPC_OP: begin
        writes_rd = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: alu_op = ALU_ADD;
          {7'h20, 3'b000}: alu_op = ALU_SUB;
          {7'h00, 3'b100}: alu_op = ALU_XOR;
          {7'h00, 3'b110}: alu_op = ALU_OR;
          {7'h00, 3'b111}: alu_op = ALU_AND;
          default:         writes_rd = 1'b0;
        endcase
      end
      OPC_LOAD: begin
        alu_b     = imm_i;
        is_load   = (funct3 == 3'b010);
        writes_rd = is_load;
      end
      OPC_STORE: begin
        alu_b    = imm_s;
        is_store = (funct3 == 3'b010) || (funct3 == 3'b000);
        is_byte  = (funct3 == 3'b000);
      end
      OPC_BRANCH: is_branch = (funct3[2:1] == 2'b00);
      OPC_JAL: begin
        is_jal    = 1'b1;
        writes_rd = 1'b1;
      end
      // Anything else retires without effect
      default: writes_rd = 1'b0;
    endcase
  end

  // BEQ on funct3 000, BNE on 001
  assign branch_taken = funct3[0] ? ~alu_equal : alu_equal;
  assign pc_target_o  = pc_i + (is_jal ? imm_j : imm_b);

  always_comb begin
    if (is_jal) begin
      rf_wdata = pc_i + INSTR_BYTES;
    end else if (is_load) begin
      rf_wdata = lsu_rdata_i;
    end else begin
      rf_wdata = alu_result;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Execute control
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    instr_ack_o = 1'b0;
    pc_set_o    = 1'b0;
    lsu_req_o   = 1'b0;
    rf_we       = 1'b0;
    unique case (state_q)
      EXEC: begin
        if (instr_valid_i) begin
          if (is_load || is_store) begin
            lsu_req_o = 1'b1;
            state_d   = WAIT_LSU;
          end else begin
            instr_ack_o = 1'b1;
            rf_we       = writes_rd;
            pc_set_o    = is_jal | (is_branch & branch_taken);
          end
        end
      end
      WAIT_LSU: begin
        // Instruction stays in the fetch buffer until the access ends
        if (lsu_done_i) begin
          instr_ack_o = 1'b1;
          rf_we       = writes_rd;
          state_d     = EXEC;
        end
      end
      default: state_d = EXEC;
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= EXEC;
    end else begin
      state_q <= state_d;
    end
  end

  assign lsu_we_o    = is_store;
  assign lsu_byte_o  = is_byte;
  assign lsu_addr_o  = alu_result;
  assign lsu_wdata_o = rf_rdata_b;

  regfile u_regfile (
    .clk       (clk),
    .rst_ni    (rst_ni),
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (rf_we),
    .waddr_i   (rd),
    .wdata_i   (rf_wdata)
  );

  alu u_alu (
    .op_i        (alu_op),
    .operand_a_i (rf_rdata_a),
    .operand_b_i (alu_b),
    .result_o    (alu_result),
    .equal_o     (alu_equal)
  );

endmodule

/* hw/core_top.sv */
/*
 * ibex_lite core top level
 * Fetch, decode/execute and load/store unit on two memory buses
 */
module core_top (
  input  logic            clk,
  input  logic            rst_ni,
  input  logic            fetch_enable_i,
  input  core_pkg::word_t boot_addr_i,
  // Instruction bus
  output logic            instr_req_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  output core_pkg::word_t instr_addr_o,
  input  core_pkg::word_t instr_rdata_i,
  // Data bus
  output logic            data_req_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  output logic            data_we_o,
  output core_pkg::be_t   data_be_o,
  output core_pkg::word_t data_addr_o,
  output core_pkg::word_t data_wdata_o,
  input  core_pkg::word_t data_rdata_i
);
  import core_pkg::*;

  // Fetch to decode
  logic  instr_valid;
  word_t instr;
  word_t pc;
  logic  instr_ack;
  logic  pc_set;
  word_t pc_target;

  // Decode to LSU
  logic  lsu_req;
  logic  lsu_we;
  logic  lsu_byte;
  word_t lsu_addr;
  word_t lsu_wdata;
  logic  lsu_done;
  word_t lsu_rdata;

  //////////////////////////////////////////////////////////////////////
  // Pipeline
  //////////////////////////////////////////////////////////////////////

  if_stage u_if_stage (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i),
    .instr_valid_o  (instr_valid),
    .instr_o        (instr),
    .pc_o           (pc),
    .instr_ack_i    (instr_ack),
    .pc_set_i       (pc_set),
    .pc_target_i    (pc_target)
  );

  id_ex_stage u_id_ex_stage (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .pc_i          (pc),
    .instr_ack_o   (instr_ack),
    .pc_set_o      (pc_set),
    .pc_target_o   (pc_target),
    .lsu_req_o     (lsu_req),
    .lsu_we_o      (lsu_we),
    .lsu_byte_o    (lsu_byte),
    .lsu_addr_o    (lsu_addr),
    .lsu_wdata_o   (lsu_wdata),
    .lsu_done_i    (lsu_done),
    .lsu_rdata_i   (lsu_rdata)
  );

  lsu u_lsu (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .lsu_req_i     (lsu_req),
    .lsu_we_i      (lsu_we),
    .lsu_byte_i    (lsu_byte),
    .lsu_addr_i    (lsu_addr),
    .lsu_wdata_i   (lsu_wdata),
    .lsu_done_o    (lsu_done),
    .lsu_rdata_o   (lsu_rdata),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o),
    .data_rdata_i  (data_rdata_i)
  );

endmodule

/* tests/tb_clock.sv */
/*
 * Testbench clock source with an 8-unit period
 */
module tb_clock (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

endmodule

/* tests/tb_mem.sv */
/*
 * Memory model for the instruction and data buses
 * One shared word array, grants and responses delayed by 0 to 3 cycles
 */
module tb_mem (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            instr_req_i,
  output logic            instr_gnt_o,
  output logic            instr_rvalid_o,
  input  core_pkg::word_t instr_addr_i,
  output core_pkg::word_t instr_rdata_o,
  input  logic            data_req_i,
  output logic            data_gnt_o,
  output logic            data_rvalid_o,
  input  logic            data_we_i,
  input  core_pkg::be_t   data_be_i,
  input  core_pkg::word_t data_addr_i,
  input  core_pkg::word_t data_wdata_i,
  output core_pkg::word_t data_rdata_o
);
  import core_pkg::*;

  localparam int unsigned DEPTH = 256;

  word_t  mem [DEPTH];
  integer seed = 32'h7a9946a9;

  // Per-bus state with prefix i for instruction and d for data
  logic   i_busy;
  int     i_gnt_wait;
  int     i_rsp_wait;
  word_t  i_rsp;
  logic   i_gnt_n;
  logic   i_rvalid_n;
  logic   i_accept;
  logic   d_busy;
  int     d_gnt_wait;
  int     d_rsp_wait;
  word_t  d_rsp;
  logic   d_gnt_n;
  logic   d_rvalid_n;
  logic   d_accept;

  function automatic int draw_delay();
    return {$random(seed)} % 4;
  endfunction

  // Grant countdown then response countdown for one bus at one edge
  task automatic step_bus(input logic req, input logic gnt_q, input logic rvalid_q,
                          inout logic busy, inout int gnt_wait, inout int rsp_wait,
                          output logic gnt_n, output logic rvalid_n, output logic accept);
    accept   = 1'b0;
    gnt_n    = 1'b0;
    rvalid_n = 1'b0;
    if (req && gnt_q) begin
      accept   = 1'b1;
      busy     = 1'b1;
      rsp_wait = draw_delay();
      gnt_wait = draw_delay();
    end else if (busy) begin
      if (rvalid_q) begin
        busy  = 1'b0;
        gnt_n = (gnt_wait == 0);
      end else if (rsp_wait == 0) begin
        rvalid_n = 1'b1;
      end else begin
        rsp_wait--;
      end
    end else begin
      if (req && gnt_wait != 0) begin
        gnt_wait--;
      end
      gnt_n = (gnt_wait == 0);
    end
  endtask

  initial begin
    // Unused words decode as no-ops and differ per address
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = word_t'(i) << 7;
    end
    $readmemh("tests/program.hex", mem);
    instr_gnt_o    = 1'b0;
    instr_rvalid_o = 1'b0;
    instr_rdata_o  = '0;
    data_gnt_o     = 1'b0;
    data_rvalid_o  = 1'b0;
    data_rdata_o   = '0;
  end

  //////////////////////////////////////////////////////////////////////
  // Both buses in one process with a fixed order of random draws
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      i_busy     = 1'b0;
      i_gnt_wait = draw_delay();
      i_gnt_n    = 1'b0;
      i_rvalid_n = 1'b0;
      d_busy     = 1'b0;
      d_gnt_wait = draw_delay();
      d_gnt_n    = 1'b0;
      d_rvalid_n = 1'b0;
    end else begin
      step_bus(instr_req_i, instr_gnt_o, instr_rvalid_o, i_busy, i_gnt_wait, i_rsp_wait,
               i_gnt_n, i_rvalid_n, i_accept);
      if (i_accept) begin
        i_rsp = mem[instr_addr_i[9:2]];
      end
      step_bus(data_req_i, data_gnt_o, data_rvalid_o, d_busy, d_gnt_wait, d_rsp_wait,
               d_gnt_n, d_rvalid_n, d_accept);
      if (d_accept) begin
        d_rsp = mem[data_addr_i[9:2]];
        if (data_we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (data_be_i[b]) begin
              mem[data_addr_i[9:2]][8*b +: 8] = data_wdata_i[8*b +: 8];
            end
          end
        end
      end
    end
    #1;
    instr_gnt_o    = i_gnt_n;
    instr_rvalid_o = i_rvalid_n;
    instr_rdata_o  = i_rsp;
    data_gnt_o     = d_gnt_n;
    data_rvalid_o  = d_rvalid_n;
    data_rdata_o   = d_rsp;
  end

endmodule

/* tests/tb_top.sv */
/*
 * ibex_lite testbench top
 * Runs the test program, checks both bus protocols and every store
 */
module tb_top;
  import core_pkg::*;

  localparam word_t BOOT_ADDR   = 32'h0000_0000;
  localparam word_t RESULT_BASE = 32'h0000_0200;
  localparam word_t POISON_ADDR = 32'h0000_0300;
  // Initial data word at 0x100 in the program image
  localparam word_t DATA_WORD   = 32'hcafe_f00d;
  localparam word_t JAL_PC      = 32'h0000_007c;
  localparam int    TIMEOUT     = 4000;

  logic  clk;
  logic  rst_ni;
  logic  fetch_enable;
  word_t boot_addr;
  logic  instr_req;
  logic  instr_gnt;
  logic  instr_rvalid;
  word_t instr_addr;
  word_t instr_rdata;
  logic  data_req;
  logic  data_gnt;
  logic  data_rvalid;
  logic  data_we;
  be_t   data_be;
  word_t data_addr;
  word_t data_wdata;
  word_t data_rdata;

  // Expected stores in program order
  word_t exp_addr [$];
  word_t exp_wdata [$];
  be_t   exp_be [$];
  int    store_idx = 0;
  logic  fetch_seen = 1'b0;

  // Bus values at the previous edge
  logic  instr_req_q = 1'b0;
  logic  instr_gnt_q = 1'b0;
  word_t instr_addr_q;
  logic  data_req_q = 1'b0;
  logic  data_gnt_q = 1'b0;
  logic  data_we_q;
  be_t   data_be_q;
  word_t data_addr_q;
  word_t data_wdata_q;

  tb_clock u_clock (
    .clk_o (clk)
  );

  tb_mem u_mem (
    .clk_i          (clk),
    .rst_ni         (rst_ni),
    .instr_req_i    (instr_req),
    .instr_gnt_o    (instr_gnt),
    .instr_rvalid_o (instr_rvalid),
    .instr_addr_i   (instr_addr),
    .instr_rdata_o  (instr_rdata),
    .data_req_i     (data_req),
    .data_gnt_o     (data_gnt),
    .data_rvalid_o  (data_rvalid),
    .data_we_i      (data_we),
    .data_be_i      (data_be),
    .data_addr_i    (data_addr),
    .data_wdata_i   (data_wdata),
    .data_rdata_o   (data_rdata)
  );

  core_top DUT (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable),
    .boot_addr_i    (boot_addr),
    .instr_req_o    (instr_req),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_addr_o   (instr_addr),
    .instr_rdata_i  (instr_rdata),
    .data_req_o     (data_req),
    .data_gnt_i     (data_gnt),
    .data_rvalid_i  (data_rvalid),
    .data_we_o      (data_we),
    .data_be_o      (data_be),
    .data_addr_o    (data_addr),
    .data_wdata_o   (data_wdata),
    .data_rdata_i   (data_rdata)
  );

  //////////////////////////////////////////////////////////////////////
  // Failure reporting
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string name, input word_t got, input word_t exp);
    $display("error at time %0t: %s is %h, expected %h", $time, name, got, exp);
    abort_run();
  endtask

  task automatic protocol_failure(input string msg);
    $display("at time %0t: %s", $time, msg);
    abort_run();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Expected stores from the RV32I rules
  //////////////////////////////////////////////////////////////////////

  task automatic push_store(input word_t addr, input word_t data);
    exp_addr.push_back(addr);
    exp_wdata.push_back(data);
    exp_be.push_back(4'b1111);
  endtask

  // SB enables one lane and repeats the byte on all lanes
  task automatic push_byte_store(input word_t word_addr, input be_t lane,
                                 input logic [7:0] data);
    exp_addr.push_back(word_addr);
    exp_wdata.push_back({4{data}});
    exp_be.push_back(lane);
  endtask

  task automatic build_expected_stores();
    word_t x1;
    word_t x3;
    x1 = (32'h12345 << 12) + 32'h678;
    x3 = (32'hf0f0f << 12) + 32'h0f0;
    push_store(RESULT_BASE + 0, x1);
    push_store(RESULT_BASE + 4, x1 + x3);
    push_store(RESULT_BASE + 8, x1 - x3);
    push_store(RESULT_BASE + 12, x1 & x3);
    push_store(RESULT_BASE + 16, x1 | x3);
    push_store(RESULT_BASE + 20, x1 ^ x3);
    // ADDI x9 with immediate -1 sign-extends the 12-bit immediate
    push_store(RESULT_BASE + 24, {{20{1'b1}}, 12'hfff});
    push_store(RESULT_BASE + 28, DATA_WORD);
    // Byte offsets 33 and 35 land in lanes 1 and 3 of the word at 32
    push_byte_store(RESULT_BASE + 32, 4'b0010, x1[7:0]);
    push_byte_store(RESULT_BASE + 32, 4'b1000, x3[7:0]);
    push_store(RESULT_BASE + 36, x3);
    push_store(RESULT_BASE + 40, x1 + x3);
    // Link register of JAL
    push_store(RESULT_BASE + 44, JAL_PC + INSTR_BYTES);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus checks at each rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_ni || !fetch_enable) begin
      assert (!instr_req && !data_req)
        else protocol_failure("bus request raised during reset or before fetch enable");
    end
    if (instr_req_q && !instr_gnt_q) begin
      assert (instr_req && instr_addr == instr_addr_q)
        else protocol_failure("instruction request dropped or changed before grant");
    end
    if (data_req_q && !data_gnt_q) begin
      assert (data_req && data_addr == data_addr_q && data_we == data_we_q &&
              data_be == data_be_q && data_wdata == data_wdata_q)
        else protocol_failure("data request dropped or changed before grant");
    end
    if (instr_req && instr_gnt) begin
      assert (instr_addr[1:0] == 2'b00)
        else protocol_failure("granted fetch address is not word aligned");
      if (!fetch_seen) begin
        assert (instr_addr == BOOT_ADDR)
          else value_mismatch("instr_addr_o", instr_addr, BOOT_ADDR);
        fetch_seen = 1'b1;
      end
    end
    if (data_req && data_gnt && data_we) begin
      assert (data_addr != POISON_ADDR)
        else protocol_failure("a store reached the poison address");
      assert (store_idx < exp_addr.size())
        else protocol_failure("more stores than expected");
      assert (data_addr == exp_addr[store_idx])
        else value_mismatch("data_addr_o", data_addr, exp_addr[store_idx]);
      assert (data_wdata == exp_wdata[store_idx])
        else value_mismatch("data_wdata_o", data_wdata, exp_wdata[store_idx]);
      assert (data_be == exp_be[store_idx])
        else value_mismatch("data_be_o", word_t'(data_be), word_t'(exp_be[store_idx]));
      store_idx++;
    end
    instr_req_q  = instr_req;
    instr_gnt_q  = instr_gnt;
    instr_addr_q = instr_addr;
    data_req_q   = data_req;
    data_gnt_q   = data_gnt;
    data_we_q    = data_we;
    data_be_q    = data_be;
    data_addr_q  = data_addr;
    data_wdata_q = data_wdata;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    int cycles;
    rst_ni       = 1'b0;
    fetch_enable = 1'b0;
    boot_addr    = BOOT_ADDR;
    build_expected_stores();
    repeat (8) @(posedge clk);
    #1 rst_ni = 1'b1;
    // Core stays quiet until fetch is enabled
    repeat (4) @(posedge clk);
    #1 fetch_enable = 1'b1;
    cycles = 0;
    while (store_idx < exp_addr.size() && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (store_idx == exp_addr.size()) begin
      // Let a stray late store show up
      repeat (16) @(negedge clk);
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("timeout after %0d cycles with %0d of %0d stores seen",
               cycles, store_idx, exp_addr.size());
      abort_run();
    end
  end

endmodule

/* ibex_lite.f */
hw/core_pkg.sv
hw/alu.sv
hw/regfile.sv
hw/lsu.sv
hw/if_stage.sv
hw/id_ex_stage.sv
hw/core_top.sv
tests/tb_clock.sv
tests/tb_mem.sv
tests/tb_top.sv

/* Bender.yml */
package:
  name: ibex_lite

sources:
  - hw/core_pkg.sv
  - hw/alu.sv
  - hw/regfile.sv
  - hw/lsu.sv
  - hw/if_stage.sv
  - hw/id_ex_stage.sv
  - hw/core_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_mem.sv
      - tests/tb_top.sv

/* tests/program.hex */
// ibex_lite test program, one 32-bit hex word per entry, four words per line
// Line comment gives the byte address of the first word and the instructions
123450b7 67808093 f0f0f1b7 0f018193 // 00: OPC_LUI x1, OPC_OPIMM x1, OPC_LUI x3, OPC_OPIMM x3
20000113 30000613 00112023 00308233 // 10: x2 result base, x12 poison, sw x1, add x4
00412223 403082b3 00512423 0030f333 // 20: sw x4, sub x5, sw x5, and x6
00612623 0030e3b3 00712823 0030c433 // 30: sw x6, or x7, sw x7, xor x8
00812a23 fff00493 00912c23 10002503 // 40: sw x8, addi x9 -1, sw x9, OPC_LOAD x10 from 0x100
00a12e23 021100a3 023101a3 00308463 // 50: sw x10, sb x1 +33, sb x3 +35, beq x1 x3 not taken
02312223 00108463 00162023 00309463 // 60: sw x3, beq x1 x1 taken, poison, bne x1 x3 taken
00162023 00109463 02412423 008005ef // 70: poison, bne x1 x1 not taken, sw x4, OPC_JAL x11 +8
00162023 02b12623 0000006f          // 80: poison, sw x11 link, jal x0 to itself
// Initial data word at byte address 0x100
@40
cafef00d
